//--- audio_recorder.f
verilog/audio_types_pkg.sv
verilog/store_link_pkg.sv
verilog/record_decimator.sv
verilog/sample_store.sv
verilog/playback_hold.sv
verilog/audio_recorder_top.sv
verif/audio_recorder_props.sv
verif/audio_recorder_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the audio recorder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f audio_recorder.f \
  --top-module audio_recorder_tb --Mdir obj_dir -o audio_recorder_sim > build.log 2>&1 \
  && ./obj_dir/audio_recorder_sim > sim.log 2>&1 \
  || { echo "build or simulation failed"; exit 1; }

grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- verif/audio_recorder_props.sv
`timescale 1ns/10ps

module audio_recorder_props
(
  input logic clock,
  input logic reset,
  input logic frame_strobe,
  input logic write_req,
  input logic write_ack,
  input logic read_req,
  input logic read_ack
);

  logic [3:0] strobe_gap;
  logic       strobe_seen;

  // cycles since the last frame strobe, saturating
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      strobe_gap  <= 4'd0;
      strobe_seen <= 1'b0;
    end
    else if (frame_strobe)
    begin
      strobe_gap  <= 4'd1;
      strobe_seen <= 1'b1;
    end
    else if (strobe_gap != 4'hf)
      strobe_gap <= strobe_gap + 4'd1;
  end

  ////////////////////
  // write link
  ////////////////////

  write_req_after_ack_low: assert property (@(posedge clock) disable iff (reset)
    $rose(write_req) |-> !write_ack)
    else $error("write req raised while ack still high");

  write_ack_rise: assert property (@(posedge clock) disable iff (reset)
    $rose(write_req) |=> write_ack)
    else $error("write ack did not follow req rise");

  write_ack_fall: assert property (@(posedge clock) disable iff (reset)
    $fell(write_req) |=> !write_ack)
    else $error("write ack did not follow req fall");

  ////////////////////
  // read link
  ////////////////////

  read_req_after_ack_low: assert property (@(posedge clock) disable iff (reset)
    $rose(read_req) |-> !read_ack)
    else $error("read req raised while ack still high");

  read_ack_rise: assert property (@(posedge clock) disable iff (reset)
    $rose(read_req) |=> read_ack)
    else $error("read ack did not follow req rise");

  read_ack_fall: assert property (@(posedge clock) disable iff (reset)
    $fell(read_req) |=> !read_ack)
    else $error("read ack did not follow req fall");

  // no back-pressure logic exists, so strobes must stay apart
  strobe_spacing: assert property (@(posedge clock) disable iff (reset)
    (frame_strobe && strobe_seen) |-> (strobe_gap >= 4'd8))
    else $error("frame strobes closer than 8 cycles");

endmodule

// the top level sees the strobe as well as both links
bind audio_recorder_top audio_recorder_props props_i
(
  .clock        (clock),
  .reset        (reset),
  .frame_strobe (frame_strobe),
  .write_req    (write_link.req),
  .write_ack    (write_ack),
  .read_req     (read_req),
  .read_ack     (read_link.ack)
);

//--- verif/audio_recorder_tb.sv
`timescale 1ns/10ps

module audio_recorder_tb
  import audio_types_pkg::*;
();

  localparam int ADDR_WIDTH        = 4;
  localparam int DECIMATION_FACTOR = 3;
  localparam int CAPACITY          = 2 ** ADDR_WIDTH - 1;
  localparam int CLOCK_PERIOD      = 100;
  localparam int STROBE_GAP        = 10;
  localparam int TOTAL_STROBES     = 167;
  localparam int MARGIN_CYCLES     = 100;
  localparam int TIMEOUT_NS = (TOTAL_STROBES * STROBE_GAP + MARGIN_CYCLES) * CLOCK_PERIOD;
  localparam logic [31:0] RANDOM_SEED = 32'h914d_eb6d;

  logic    clock = 1'b0;
  logic    reset;
  logic    frame_strobe;
  sample_t mic_sample;
  logic    playback_mode;
  sample_t speaker_sample;

  // reference model state
  sample_t kept[$];
  sample_t expected_speaker;
  int      rec_count;
  int      play_count;
  int      error_count;
  int      check_count;
  int      seed_value;

  audio_recorder_top #(
    .ADDR_WIDTH        (ADDR_WIDTH),
    .DECIMATION_FACTOR (DECIMATION_FACTOR)
  ) dut_i (
    .clock          (clock),
    .reset          (reset),
    .frame_strobe   (frame_strobe),
    .mic_sample     (mic_sample),
    .playback_mode  (playback_mode),
    .speaker_sample (speaker_sample)
  );

  always #(CLOCK_PERIOD / 2) clock = ~clock;

  ////////////////////
  // helpers
  ////////////////////

  task automatic next_cycle();
    @(posedge clock);
    #1;
  endtask

  // one strobe, then idle until just before the next one
  task automatic issue_strobe(input sample_t sample);
    frame_strobe = 1'b1;
    mic_sample   = sample;
    next_cycle();
    frame_strobe = 1'b0;
    repeat (STROBE_GAP - 1) next_cycle();
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    check_count++;
    if (actual !== expected)
    begin
      error_count++;
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
    end
  endtask

  task automatic begin_recording();
    playback_mode = 1'b0;
    kept.delete();
    rec_count = 0;
    repeat (2) next_cycle();
  endtask

  task automatic begin_playback();
    playback_mode    = 1'b1;
    play_count       = 0;
    expected_speaker = '0;
    repeat (2) next_cycle();
  endtask

  // every third strobe is kept until the store is full, speaker stays muted
  task automatic record_strobes(input int count);
    sample_t sample;
    for (int i = 0; i < count; i++)
    begin
      sample = sample_t'($urandom);
      issue_strobe(sample);
      rec_count++;
      if (rec_count % DECIMATION_FACTOR == 0 && kept.size() < CAPACITY)
        kept.push_back(sample);
      check_value("speaker_sample", 32'(speaker_sample), 32'h0);
    end
  endtask

  // every third strobe fetches the next kept sample, wrapping at the length
  task automatic play_strobes(input int count);
    int fetch_index;
    for (int i = 0; i < count; i++)
    begin
      issue_strobe(sample_t'($urandom));
      play_count++;
      if (play_count % DECIMATION_FACTOR == 0)
      begin
        if (kept.size() == 0)
          expected_speaker = '0;
        else
        begin
          fetch_index = (play_count / DECIMATION_FACTOR - 1) % kept.size();
          expected_speaker = kept[fetch_index];
        end
      end
      check_value("speaker_sample", 32'(speaker_sample), 32'(expected_speaker));
    end
  endtask

  ////////////////////
  // directed tests
  ////////////////////

  task automatic test_reset_state();
    check_value("speaker_sample", 32'(speaker_sample), 32'h0);
    repeat (5) next_cycle();
    check_value("speaker_sample", 32'(speaker_sample), 32'h0);
  endtask

  task automatic test_basic_playback();
    begin_recording();
    record_strobes(12);
    begin_playback();
    play_strobes(12);
  endtask

  // continues the session above past the recording end
  task automatic test_playback_wrap();
    play_strobes(12);
  endtask

  task automatic test_full_store();
    begin_recording();
    record_strobes(60);
    begin_playback();
    play_strobes(48);
  endtask

  task automatic test_rerecord_and_short();
    begin_recording();
    record_strobes(6);
    begin_playback();
    play_strobes(9);
    // two strobes keep nothing, so playback is silent
    begin_recording();
    record_strobes(2);
    begin_playback();
    play_strobes(6);
  endtask

  initial
  begin
    seed_value    = $urandom(RANDOM_SEED);
    reset         = 1'b1;
    frame_strobe  = 1'b0;
    mic_sample    = '0;
    playback_mode = 1'b0;
    error_count   = 0;
    check_count   = 0;
    repeat (5) @(posedge clock);
    #1;
    reset = 1'b0;
    next_cycle();
    test_reset_state();
    test_basic_playback();
    test_playback_wrap();
    test_full_store();
    test_rerecord_and_short();
    $display("checks run: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("All tests passed!");
    else
      $display("Test failures found");
    $finish;
  end

  // watchdog sized from the strobe count of all tests
  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout: the tests did not finish in time, errors so far: %0d", error_count);
    $display("Test failures found");
    $finish;
  end

endmodule

//--- verilog/audio_recorder_top.sv
`timescale 1ns/10ps

module audio_recorder_top
  import audio_types_pkg::*;
  import store_link_pkg::*;
#(
  parameter int ADDR_WIDTH        = 16,
  parameter int DECIMATION_FACTOR = 8
)
(
  input  logic    clock,
  input  logic    reset,
  input  logic    frame_strobe,
  input  sample_t mic_sample,
  input  logic    playback_mode,
  output sample_t speaker_sample
);

  store_write_t  write_link;
  logic          write_ack;
  store_read_t   read_link;
  logic          read_req;
  session_mode_t session_mode;

  // producer side, keeps every Nth mic sample
  record_decimator #(
    .DECIMATION_FACTOR (DECIMATION_FACTOR)
  ) decimator_i (
    .clock        (clock),
    .reset        (reset),
    .frame_strobe (frame_strobe),
    .mic_sample   (mic_sample),
    .session_mode (session_mode),
    .write_ack    (write_ack),
    .write_link   (write_link)
  );

  sample_store #(
    .ADDR_WIDTH (ADDR_WIDTH)
  ) store_i (
    .clock         (clock),
    .reset         (reset),
    .playback_mode (playback_mode),
    .write_link    (write_link),
    .read_req      (read_req),
    .write_ack     (write_ack),
    .read_link     (read_link),
    .session_mode  (session_mode)
  );

  // consumer side, paces playback at the same rate
  playback_hold #(
    .DECIMATION_FACTOR (DECIMATION_FACTOR)
  ) hold_i (
    .clock          (clock),
    .reset          (reset),
    .frame_strobe   (frame_strobe),
    .session_mode   (session_mode),
    .read_link      (read_link),
    .read_req       (read_req),
    .speaker_sample (speaker_sample)
  );

endmodule

//--- verilog/audio_types_pkg.sv
package audio_types_pkg;

  // width of one PCM sample on the codec byte path
  localparam int SAMPLE_WIDTH = 8;

  // one signed PCM sample, top byte of the codec word
  typedef logic [SAMPLE_WIDTH-1:0] sample_t;

  // registered session mode, owned by the sample store
  // record keeps decimated mic samples, play loops them to the speaker
  typedef enum logic
  {
    RECORDING = 1'b0,
    PLAYING   = 1'b1
  } session_mode_t;

  // reset value of the decimation counters is FACTOR-1, so the
  // first kept sample is the FACTOR-th strobe of a session

endpackage

//--- verilog/playback_hold.sv
`timescale 1ns/10ps

module playback_hold
  import audio_types_pkg::*;
  import store_link_pkg::*;
#(
  parameter int DECIMATION_FACTOR = 8
)
(
  input  logic          clock,
  input  logic          reset,
  input  logic          frame_strobe,
  input  session_mode_t session_mode,
  input  store_read_t   read_link,
  output logic          read_req,
  output sample_t       speaker_sample
);

  localparam int CNT_W = (DECIMATION_FACTOR > 1) ? $clog2(DECIMATION_FACTOR) : 1;
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(DECIMATION_FACTOR - 1);

  logic [CNT_W-1:0] count;
  logic             fetch;
  hs_phase_t        phase;

  // every FACTOR-th strobe in play mode fetches the next entry
  assign fetch = frame_strobe && (session_mode == PLAYING) && (count == '0);

  always_ff @(posedge clock)
  begin
    if (reset || session_mode != PLAYING)
      count <= RELOAD;
    else if (fetch)
      count <= RELOAD;
    else if (frame_strobe)
      count <= count - 1'b1;
  end

  ////////////////////
  // read handshake
  ////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
      phase <= IDLE;
    else
      case (phase)
        IDLE:    if (fetch) phase <= REQUEST;
        REQUEST: if (read_link.ack) phase <= RELEASE;
        RELEASE: if (!read_link.ack) phase <= IDLE;
        default: phase <= IDLE;
      endcase
  end

  assign read_req = (phase == REQUEST);

  // speaker is muted while recording
  // otherwise the last fetched sample is held until the next one
  always_ff @(posedge clock)
  begin
    if (reset || session_mode != PLAYING)
      speaker_sample <= '0;
    else if (phase == REQUEST && read_link.ack)
      speaker_sample <= read_link.sample;
  end

endmodule

//--- verilog/record_decimator.sv
`timescale 1ns/10ps

module record_decimator
  import audio_types_pkg::*;
  import store_link_pkg::*;
#(
  parameter int DECIMATION_FACTOR = 8
)
(
  input  logic          clock,
  input  logic          reset,
  input  logic          frame_strobe,
  input  sample_t       mic_sample,
  input  session_mode_t session_mode,
  input  logic          write_ack,
  output store_write_t  write_link
);

  localparam int CNT_W = (DECIMATION_FACTOR > 1) ? $clog2(DECIMATION_FACTOR) : 1;
  localparam logic [CNT_W-1:0] RELOAD = CNT_W'(DECIMATION_FACTOR - 1);

  logic [CNT_W-1:0] count;
  logic             capture;
  hs_phase_t        phase;
  sample_t          held_sample;

  // the strobe that finds the count at zero keeps its sample
  assign capture = frame_strobe && (session_mode == RECORDING) && (count == '0);

  ////////////////////
  // strobe counter
  ////////////////////

  // reloads outside record mode, so each session starts a fresh count
  always_ff @(posedge clock)
  begin
    if (reset || session_mode != RECORDING)
      count <= RELOAD;
    else if (capture)
      count <= RELOAD;
    else if (frame_strobe)
      count <= count - 1'b1;
  end

  always_ff @(posedge clock)
  begin
    if (capture)
      held_sample <= mic_sample;
  end

  ////////////////////
  // write handshake
  ////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
      phase <= IDLE;
    else
      case (phase)
        IDLE:    if (capture) phase <= REQUEST;
        REQUEST: if (write_ack) phase <= RELEASE;
        RELEASE: if (!write_ack) phase <= IDLE;
        default: phase <= IDLE;
      endcase
  end

  assign write_link = '{req: (phase == REQUEST), sample: held_sample};

endmodule

//--- verilog/sample_store.sv
`timescale 1ns/10ps

module sample_store
  import audio_types_pkg::*;
  import store_link_pkg::*;
#(
  parameter int ADDR_WIDTH = 16
)
(
  input  logic          clock,
  input  logic          reset,
  input  logic          playback_mode,
  input  store_write_t  write_link,
  input  logic          read_req,
  output logic          write_ack,
  output store_read_t   read_link,
  output session_mode_t session_mode
);

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  sample_t               mem [DEPTH];
  logic [ADDR_WIDTH-1:0] write_ptr;
  logic [ADDR_WIDTH-1:0] read_ptr;
  logic [ADDR_WIDTH-1:0] read_next;
  logic [ADDR_WIDTH-1:0] length;
  session_mode_t         next_mode;
  logic                  mode_change;
  logic                  full;
  logic                  write_en;
  logic                  read_en;
  logic                  read_ack;
  sample_t               read_sample;

  assign next_mode   = playback_mode ? PLAYING : RECORDING;
  assign mode_change = (next_mode != session_mode);

  // the last address stays unused, so at most DEPTH-1 samples are kept
  assign full = (write_ptr == {ADDR_WIDTH{1'b1}});

  // act only on the rising edge of each req
  assign write_en = write_link.req && !write_ack && (session_mode == RECORDING)
                    && !mode_change && !full;
  assign read_en  = read_req && !read_ack;
  assign read_next = read_ptr + 1'b1;

  ////////////////////
  // mode and length
  ////////////////////

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      session_mode <= RECORDING;
      length       <= '0;
    end
    else
    begin
      session_mode <= next_mode;
      // fill level at the switch becomes the recording length
      if (mode_change && next_mode == PLAYING)
        length <= write_ptr;
    end
  end

  ////////////////////
  // pointers
  ////////////////////

  // any mode change restarts both pointers at the first entry
  always_ff @(posedge clock)
  begin
    if (reset || mode_change)
    begin
      write_ptr <= '0;
      read_ptr  <= '0;
    end
    else
    begin
      if (write_en)
        write_ptr <= write_ptr + 1'b1;
      if (read_en && session_mode == PLAYING && length != '0)
        read_ptr <= (read_next == length) ? '0 : read_next;
    end
  end

  ////////////////////
  // handshakes and memory
  ////////////////////

  // each ack edge follows its req edge by one cycle
  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      write_ack <= 1'b0;
      read_ack  <= 1'b0;
    end
    else
    begin
      write_ack <= write_link.req;
      read_ack  <= read_req;
    end
  end

  always_ff @(posedge clock)
  begin
    if (write_en)
      mem[write_ptr] <= write_link.sample;
    // an empty recording plays back silence
    if (read_en)
      read_sample <= (length == '0) ? '0 : mem[read_ptr];
  end

  assign read_link = '{ack: read_ack, sample: read_sample};

endmodule

//--- verilog/store_link_pkg.sv
package store_link_pkg;

  import audio_types_pkg::*;

  // four-phase state of a link master
  // IDLE waits for a capture, REQUEST holds req high until ack,
  // RELEASE waits for ack to drop before the next transfer
  typedef enum logic [1:0]
  {
    IDLE    = 2'd0,
    REQUEST = 2'd1,
    RELEASE = 2'd2
  } hs_phase_t;

  // decimator to store, sample stable while req is high
  typedef struct packed {
    logic    req;
    sample_t sample;
  } store_write_t;

  // store to playback hold, sample valid while ack is high
  typedef struct packed {
    logic    ack;
    sample_t sample;
  } store_read_t;

endpackage
